//--- verilog/dlx_pkg.sv
package dlx_pkg;

   typedef logic [0:31] instr_t;   // Bit 0 is the MSB
   typedef logic [31:0] word_t;
   typedef logic [4:0]  reg_idx_t;
   typedef logic [0:5]  opcode_t;
   typedef logic [0:5]  func_t;
   typedef logic [4:0]  alu_op_t;

   // Primary opcodes that carry a function field
   localparam opcode_t SPECIAL = 6'h00;
   localparam opcode_t FPARITH = 6'h01;   // MULT and FP arithmetic

   localparam func_t ADD  = 6'h20;
   localparam func_t ADDU = 6'h21;
   localparam func_t SUB  = 6'h18;
   localparam func_t SUBU = 6'h19;
   localparam func_t XOR  = 6'h26;
   localparam func_t NOP  = 6'h15;

   localparam opcode_t ADDI  = 6'h08;
   localparam opcode_t ADDUI = 6'h09;
   localparam opcode_t SUBI  = 6'h0a;
   localparam opcode_t SUBUI = 6'h0b;
   localparam opcode_t SGEI  = 6'h1d;
   localparam opcode_t LHI   = 6'h0f;
   localparam opcode_t J     = 6'h02;
   localparam opcode_t JAL   = 6'h03;
   localparam opcode_t JR    = 6'h0c;
   localparam opcode_t JALR  = 6'h13;
   localparam opcode_t BEQZ  = 6'h04;
   localparam opcode_t BNEZ  = 6'h05;
   localparam opcode_t LW    = 6'h23;
   localparam opcode_t LH    = 6'h21;
   localparam opcode_t LB    = 6'h20;
   localparam opcode_t LBU   = 6'h24;
   localparam opcode_t SW    = 6'h2b;
   localparam opcode_t SH    = 6'h29;
   localparam opcode_t SB    = 6'h28;
   localparam opcode_t TRAP  = 6'h11;
   localparam opcode_t RFE   = 6'h10;

   localparam alu_op_t ALU_AND = 5'd0;
   localparam alu_op_t ALU_OR  = 5'd1;
   localparam alu_op_t ALU_ADD = 5'd2;
   localparam alu_op_t ALU_SUB = 5'd3;
   localparam alu_op_t ALU_XOR = 5'd4;
   localparam alu_op_t ALU_SGE = 5'd9;

   typedef struct packed {
      logic     reg_wr;
      reg_idx_t reg_dst;
      reg_idx_t rs2_sel;
      logic     ext_op;       // Sign extend when set
      logic     alu_src;      // Register operand when set
      alu_op_t  alu_op;
      logic     mem_wr;
      logic     mem_to_reg;
      logic     is_load;      // LW, LH or LB
   } ctrl_t;

   typedef struct packed {
      logic  take;
      word_t target;
   } br_t;

endpackage

//--- verilog/dlx_control.sv
module dlx_control import dlx_pkg::*; (
   input  instr_t instr,
   output ctrl_t  ctrl
);

   opcode_t  opcode;
   func_t    func;
   reg_idx_t rs2_field;
   reg_idx_t rd_field;
   logic     r_type;
   logic     j_type;
   logic     i_type;
   logic     load_op;
   logic     store_op;
   logic     no_write;
   alu_op_t  alu_op;

   assign opcode    = instr[0:5];
   assign rs2_field = instr[11:15];
   assign rd_field  = instr[16:20];
   assign func      = instr[26:31];

   // NOP shares opcode 0 but is not treated as R-type
   assign r_type = ((opcode == SPECIAL) && (func != NOP)) ||
                   (opcode == FPARITH);

   // Unconditional jumps only, branches are I-type
   assign j_type = (opcode == J)   ||
                   (opcode == JAL) ||
                   (opcode == RFE) ||
                   (opcode == TRAP);

   assign i_type = !r_type && !j_type;

   assign load_op = (opcode == LW) ||
                    (opcode == LH) ||
                    (opcode == LB);

   assign store_op = (opcode == SW) ||
                     (opcode == SH) ||
                     (opcode == SB);

   // I-type forms with no destination register
   assign no_write = (opcode == BEQZ) ||
                     (opcode == BNEZ) ||
                     (opcode == JR)   ||
                     (opcode == JALR) ||
                     store_op;

   always_comb begin
      alu_op = '0;   // No ALU use
      if ((opcode == ADDI) || (opcode == ADDUI) ||
          (opcode == LW)   || (opcode == LB)    ||
          (opcode == SW)   || (opcode == SB)    ||
          ((opcode == SPECIAL) && ((func == ADD) || (func == ADDU)))) begin
         alu_op = ALU_ADD;
      end else if ((opcode == SUBI) || (opcode == SUBUI) ||
                   ((opcode == SPECIAL) && ((func == SUB) || (func == SUBU)))) begin
         alu_op = ALU_SUB;
      end else if ((opcode == SPECIAL) && (func == XOR)) begin
         alu_op = ALU_XOR;
      end else if (opcode == SGEI) begin
         alu_op = ALU_SGE;
      end
   end

   always_comb begin
      ctrl.reg_wr     = r_type || (i_type && !no_write);
      ctrl.reg_dst    = i_type ? rs2_field : rd_field;
      ctrl.rs2_sel    = rs2_field;
      ctrl.ext_op     = (opcode == SUBI) ||
                        (opcode == ADDI) ||
                        (opcode == SGEI) ||
                        load_op          ||
                        store_op;
      ctrl.alu_src    = r_type;
      ctrl.alu_op     = alu_op;
      ctrl.mem_wr     = (opcode == SW) || (opcode == SB);
      ctrl.mem_to_reg = (opcode == LW);   // LH and LB go through the ALU path
      ctrl.is_load    = load_op;
   end

   always_comb begin : p_type_check
      a_type_excl: assert (!(r_type && j_type))
         else $error("instruction classed as both R-type and J-type");
   end

endmodule

//--- verilog/dlx_jump_branch.sv
module dlx_jump_branch import dlx_pkg::*; (
   input  instr_t instr,
   input  word_t  rs1,
   input  word_t  pc_plus_four,
   output br_t    br
);

   opcode_t opcode;
   word_t   off26;
   word_t   off16;
   word_t   rel26_target;
   word_t   rel16_target;
   logic    rs1_zero;

   assign opcode = instr[0:5];

   assign off26 = {{6{instr[6]}}, instr[6:31]};
   assign off16 = {{16{instr[16]}}, instr[16:31]};

   assign rel26_target = pc_plus_four + off26;
   assign rel16_target = pc_plus_four + off16;

   assign rs1_zero = (rs1 == '0);

   always_comb begin
      br.take   = 1'b0;
      br.target = pc_plus_four;   // Fall through
      case (opcode)
         J, JAL: begin
            br.take   = 1'b1;
            br.target = rel26_target;
         end
         JR, JALR: begin
            br.take   = 1'b1;
            br.target = rs1;
         end
         BEQZ: begin
            br.take   = rs1_zero;
            br.target = rel16_target;
         end
         BNEZ: begin
            br.take   = !rs1_zero;
            br.target = rel16_target;
         end
         default: begin
            br.take   = 1'b0;
            br.target = pc_plus_four;
         end
      endcase
   end

endmodule

//--- verilog/dlx_hazard_merge.sv
module dlx_hazard_merge import dlx_pkg::*; #(
   parameter int KILL_SLOTS = 1
) (
   input  logic  clk,
   input  logic  arst_n,
   input  ctrl_t ctrl_in,
   input  br_t   br_in,
   output ctrl_t ctrl,
   output br_t   branch,
   output logic  stall,
   output logic  kill_next
);

   localparam int CNT_W = $clog2(KILL_SLOTS + 1);

   typedef logic [CNT_W-1:0] kill_cnt_t;

   kill_cnt_t kill_cnt;   // Instructions still to suppress
   logic      killed;
   logic      load_hit;
   ctrl_t     ctrl_d;
   br_t       branch_d;

   if ((KILL_SLOTS < 1) || (KILL_SLOTS > 2)) begin : g_bad_slots
      $error("KILL_SLOTS must be 1 or 2");
   end

   assign killed   = (kill_cnt != '0);
   assign load_hit = ctrl_in.is_load && !killed;

   // Only side effects are dropped
   always_comb begin
      ctrl_d   = ctrl_in;
      branch_d = br_in;
      if (killed) begin
         ctrl_d.reg_wr     = 1'b0;
         ctrl_d.mem_wr     = 1'b0;
         ctrl_d.mem_to_reg = 1'b0;
         ctrl_d.is_load    = 1'b0;
         branch_d.take     = 1'b0;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         kill_cnt  <= '0;
         ctrl      <= '0;
         branch    <= '0;
         stall     <= 1'b0;
         kill_next <= 1'b0;
      end else begin
         ctrl      <= ctrl_d;
         branch    <= branch_d;
         stall     <= load_hit;
         kill_next <= load_hit;
         if (load_hit) begin
            kill_cnt <= kill_cnt_t'(KILL_SLOTS);
         end else if (killed) begin
            kill_cnt <= kill_cnt - kill_cnt_t'(1);
         end
      end
   end

   // The slot after a load is killed and cannot stall
   a_no_stall_killed: assert property (
      @(posedge clk) disable iff (!arst_n) stall |=> !stall)
      else $error("stall raised in the slot after a load");

   a_mem_excl: assert property (
      @(posedge clk) disable iff (!arst_n) !(ctrl.mem_wr && ctrl.mem_to_reg))
      else $error("mem_wr and mem_to_reg both set");

endmodule

//--- verilog/dlx_id_stage.sv
module dlx_id_stage import dlx_pkg::*; #(
   parameter int KILL_SLOTS = 1   // Instructions suppressed after a load
) (
   input  logic   clk,
   input  logic   arst_n,
   input  instr_t instr,
   input  word_t  rs1,
   input  word_t  pc_plus_four,
   output ctrl_t  ctrl,
   output br_t    branch,
   output logic   stall,
   output logic   kill_next
);

   ctrl_t dec_ctrl;
   br_t   dec_br;

   dlx_control i_dlx_control (
      .instr (instr),
      .ctrl  (dec_ctrl)
   );

   dlx_jump_branch i_dlx_jump_branch (
      .instr        (instr),
      .rs1          (rs1),
      .pc_plus_four (pc_plus_four),
      .br           (dec_br)
   );

   dlx_hazard_merge #(
      .KILL_SLOTS (KILL_SLOTS)
   ) i_dlx_hazard_merge (
      .clk       (clk),
      .arst_n    (arst_n),
      .ctrl_in   (dec_ctrl),
      .br_in     (dec_br),
      .ctrl      (ctrl),
      .branch    (branch),
      .stall     (stall),
      .kill_next (kill_next)
   );

endmodule

//--- include/dlx_id_ref.svh
`ifndef DLX_ID_REF_SVH
`define DLX_ID_REF_SVH

function automatic ctrl_t ref_ctrl(instr_t instr);
   opcode_t op;
   func_t   fn;
   logic    rt;
   logic    jt;
   ctrl_t   c;
   op = instr[0:5];
   fn = instr[26:31];
   rt = ((op == SPECIAL) && (fn != NOP)) || (op == FPARITH);
   jt = op inside {J, JAL, RFE, TRAP};
   c = '0;
   c.rs2_sel    = instr[11:15];
   c.reg_dst    = (rt || jt) ? instr[16:20] : instr[11:15];
   c.reg_wr     = rt || (!jt && !(op inside {BEQZ, BNEZ, JR, JALR, SW, SH, SB}));
   c.ext_op     = op inside {SUBI, ADDI, SGEI, LW, LH, LB, SW, SH, SB};
   c.alu_src    = rt;
   c.mem_wr     = op inside {SW, SB};
   c.mem_to_reg = (op == LW);
   c.is_load    = op inside {LW, LH, LB};
   if ((op inside {ADDI, ADDUI, LW, LB, SW, SB}) ||
       ((op == SPECIAL) && (fn inside {ADD, ADDU})))
      c.alu_op = ALU_ADD;
   else if ((op inside {SUBI, SUBUI}) || ((op == SPECIAL) && (fn inside {SUB, SUBU})))
      c.alu_op = ALU_SUB;
   else if ((op == SPECIAL) && (fn == XOR))
      c.alu_op = ALU_XOR;
   else if (op == SGEI)
      c.alu_op = ALU_SGE;
   return c;
endfunction

function automatic br_t ref_branch(instr_t instr, word_t rs1, word_t pc_plus_four);
   opcode_t op;
   br_t     b;
   op = instr[0:5];
   b.take   = 1'b0;
   b.target = pc_plus_four;
   if (op inside {J, JAL}) begin
      b.take   = 1'b1;
      b.target = pc_plus_four + {{6{instr[6]}}, instr[6:31]};
   end else if (op inside {JR, JALR}) begin
      b.take   = 1'b1;
      b.target = rs1;
   end else if (op inside {BEQZ, BNEZ}) begin
      b.take   = (op == BEQZ) ? (rs1 == 0) : (rs1 != 0);
      b.target = pc_plus_four + {{16{instr[16]}}, instr[16:31]};
   end
   return b;
endfunction

// Kill model, one call per sampled instruction
function automatic void ref_merge(input ctrl_t c_in, input br_t b_in, input int kill_slots,
                                  inout int kill_cnt, output ctrl_t c_out,
                                  output br_t b_out, output logic stall,
                                  output logic kill_next);
   c_out = c_in;
   b_out = b_in;
   stall = 1'b0;
   if (kill_cnt > 0) begin
      c_out.reg_wr     = 1'b0;
      c_out.mem_wr     = 1'b0;
      c_out.mem_to_reg = 1'b0;
      c_out.is_load    = 1'b0;
      b_out.take       = 1'b0;
      kill_cnt--;
   end else if (c_in.is_load) begin
      stall    = 1'b1;
      kill_cnt = kill_slots;
   end
   kill_next = stall;
endfunction

`endif

//--- verification/dlx_id_stage_tb.sv
module dlx_id_stage_tb import dlx_pkg::*; ();

   timeunit 1ns;
   timeprecision 100ps;

   `include "dlx_id_ref.svh"

   localparam int KILL_SLOTS      = 1;
   localparam int RESET_CYCLES    = 5;
   localparam int DIRECTED_CYCLES = 60;   // Directed drives, NOP padding and drain
   localparam int RANDOM_COUNT    = 400;
   localparam int CYCLE_LIMIT     = RESET_CYCLES + DIRECTED_CYCLES + RANDOM_COUNT + 20;
   localparam instr_t NOP_INSTR   = {SPECIAL, 20'h0, NOP};
   localparam word_t PC           = 32'h0000_1000;

   typedef struct packed {
      ctrl_t  c;
      br_t    b;
      logic   stall;
      logic   kill_next;
      instr_t instr;
   } exp_t;

   logic   clk = 1'b0;
   logic   arst_n;
   instr_t instr;
   word_t  rs1;
   word_t  pc_plus_four;
   ctrl_t  ctrl;
   br_t    branch;
   logic   stall;
   logic   kill_next;

   exp_t    exp_q[$];
   int      kill_cnt = 0;    // Model of the merge counter
   int      seed = 32'hfab6777b;
   int      pass_cnt = 0;
   int      fail_cnt = 0;
   int      fail_mark = 0;
   int      cycle_cnt = 0;
   opcode_t op_list [0:22] = '{SPECIAL, FPARITH, ADDI, ADDUI, SUBI, SUBUI, SGEI, LHI, J, JAL,
                               JR, JALR, BEQZ, BNEZ, LW, LH, LB, LBU, SW, SH, SB, TRAP, RFE};
   func_t   func_list [0:5] = '{ADD, ADDU, SUB, SUBU, XOR, NOP};

   dlx_id_stage #(
      .KILL_SLOTS (KILL_SLOTS)
   ) i_dlx_id_stage (
      .clk          (clk),
      .arst_n       (arst_n),
      .instr        (instr),
      .rs1          (rs1),
      .pc_plus_four (pc_plus_four),
      .ctrl         (ctrl),
      .branch       (branch),
      .stall        (stall),
      .kill_next    (kill_next)
   );

   always #10 clk = ~clk;

   function automatic instr_t make_itype(opcode_t op, reg_idx_t a, reg_idx_t d,
                                         logic [15:0] imm);
      return {op, a, d, imm};
   endfunction

   function automatic instr_t make_rtype(func_t fn, reg_idx_t a, reg_idx_t b, reg_idx_t d);
      return {SPECIAL, a, b, d, 5'd0, fn};
   endfunction

   function automatic instr_t make_jtype(opcode_t op, logic [25:0] off);
      return {op, off};
   endfunction

   task automatic check(input logic ok, input string what, input instr_t ins);
      assert (ok) pass_cnt = pass_cnt + 1;
      else begin
         fail_cnt = fail_cnt + 1;
         $display("CHECK FAILED at %0t: %s wrong for instr %h", $time, what, ins);
      end
   endtask

   // Expectation is due one cycle after the drive
   task automatic drive(input instr_t ins, input word_t r1, input word_t pc);
      exp_t  e;
      ctrl_t c;
      br_t   b;
      logic  st;
      logic  kn;
      @(negedge clk);
      instr        = ins;
      rs1          = r1;
      pc_plus_four = pc;
      ref_merge(ref_ctrl(ins), ref_branch(ins, r1, pc), KILL_SLOTS, kill_cnt, c, b, st, kn);
      e = {c, b, st, kn, ins};
      exp_q.push_back(e);
   endtask

   task automatic end_test(input string name);
      drive(NOP_INSTR, '0, PC);   // Flush the kill window
      drive(NOP_INSTR, '0, PC);
      while (exp_q.size() != 0) @(negedge clk);
      $display("test %-8s done, %0d failures", name, fail_cnt - fail_mark);
      fail_mark = fail_cnt;
   endtask

   task automatic drive_random();
      instr_t ins;
      word_t  r1;
      int     idx;
      ins = $random(seed);
      idx = $unsigned($random(seed)) % 23;
      ins[0:5] = op_list[idx];
      if (ins[0:5] == SPECIAL) begin
         idx = $unsigned($random(seed)) % 6;
         ins[26:31] = func_list[idx];
      end
      r1 = (($random(seed) & 3) == 0) ? '0 : $random(seed);   // Zero often enough for BEQZ
      drive(ins, r1, $random(seed) & 32'hffff_fffc);
   endtask

   always begin : p_compare
      exp_t e;
      @(posedge clk);
      #2;
      if (exp_q.size() > 0) begin
         e = exp_q.pop_front();
         check(ctrl == e.c, "ctrl", e.instr);
         check(branch == e.b, "branch", e.instr);
         check((stall == e.stall) && (kill_next == e.kill_next), "stall/kill_next", e.instr);
      end
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt > CYCLE_LIMIT) begin
         $display("Timeout: run did not end within %0d cycles", CYCLE_LIMIT);
         $display("Result: FAILED");
         $finish;
      end
   end

   initial begin
      arst_n       = 1'b0;
      instr        = NOP_INSTR;
      rs1          = '0;
      pc_plus_four = '0;
      repeat (RESET_CYCLES) @(negedge clk);
      arst_n = 1'b1;
      #1;
      check((ctrl == '0) && !branch.take && !stall && !kill_next, "reset state", instr);
      end_test("reset");

      drive(make_rtype(ADD, 5'd1, 5'd2, 5'd3), '0, PC);
      drive(make_rtype(SUBU, 5'd4, 5'd5, 5'd6), '0, PC);
      drive(make_rtype(XOR, 5'd7, 5'd8, 5'd9), '0, PC);
      drive(make_itype(ADDI, 5'd1, 5'd10, 16'h8001), '0, PC);
      drive(make_itype(SUBUI, 5'd2, 5'd11, 16'h0010), '0, PC);
      drive(make_itype(SGEI, 5'd3, 5'd12, 16'hffff), '0, PC);
      drive(make_itype(LHI, 5'd0, 5'd13, 16'h1234), '0, PC);
      drive(make_itype(SW, 5'd4, 5'd14, 16'h0004), '0, PC);
      drive(make_itype(SB, 5'd5, 5'd15, 16'hfffc), '0, PC);
      drive(make_itype(SH, 5'd6, 5'd16, 16'h0002), '0, PC);
      end_test("decode");

      drive(make_jtype(J, 26'h0000100), '0, PC);
      drive(make_jtype(JAL, 26'h3fffff0), '0, PC);   // Negative offset
      drive(make_itype(JR, 5'd1, 5'd0, 16'h0), 32'h0000_1234, PC);
      drive(make_itype(JALR, 5'd2, 5'd0, 16'h0), 32'h8000_0000, PC);
      drive(make_itype(BEQZ, 5'd3, 5'd0, 16'h0040), '0, PC);
      drive(make_itype(BEQZ, 5'd3, 5'd0, 16'h0040), 32'd5, PC);
      drive(make_itype(BNEZ, 5'd4, 5'd0, 16'hfff0), 32'd5, PC);
      drive(make_itype(BNEZ, 5'd4, 5'd0, 16'hfff0), '0, PC);
      end_test("branch");

      drive(make_itype(LW, 5'd1, 5'd2, 16'h0008), '0, PC);
      drive(make_itype(SW, 5'd2, 5'd3, 16'h000c), '0, PC);
      drive(make_itype(BEQZ, 5'd0, 5'd0, 16'h0020), '0, PC);
      end_test("loaduse");

      drive(make_itype(LW, 5'd1, 5'd2, 16'h0000), '0, PC);
      drive(make_itype(LB, 5'd3, 5'd4, 16'h0001), '0, PC);
      drive(make_rtype(ADD, 5'd2, 5'd4, 5'd5), '0, PC);
      end_test("loadload");

      repeat (RANDOM_COUNT) drive_random();
      end_test("random");

      $display("Checks passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

endmodule

//--- dlx_id_stage.f
+incdir+include
verilog/dlx_pkg.sv
verilog/dlx_control.sv
verilog/dlx_jump_branch.sv
verilog/dlx_hazard_merge.sv
verilog/dlx_id_stage.sv
verification/dlx_id_stage_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the ID stage testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f dlx_id_stage.f --top-module dlx_id_stage_tb \
   || { echo "Verilator build failed"; exit 1; }
out=$(./obj_dir/Vdlx_id_stage_tb)
echo "$out"
echo "$out" | grep -qx "Result: PASSED" && echo "Simulation run ok" \
   || { echo "Simulation run failed"; exit 1; }
